// File: sdram_sys.f
rtl/sdram_pkg.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_arbiter.sv
rtl/sdram_ctrl.sv
rtl/sdram_sys.sv
test/sdram_model.sv
test/tb_sdram_sys.sv

// File: Makefile
TOP = tb_sdram_sys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sdram_sys.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sdram_sys.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/sdram_cases.txt
# ch we addr wdata mask start, all hex; addr is bank, column, row
# we 1 = write; mask bit set keeps that byte; start counts cycles after reset
0 1 000123 a5a5 0 5
1 1 0ff456 1234 0 5
2 1 2a0789 beef 0 5
0 0 000123 0000 0 40
1 0 0ff456 0000 0 40
2 0 2a0789 0000 0 40
0 1 000123 ffff 1 a0
1 1 0ff456 5678 2 a0
2 0 000123 0000 0 a0
0 0 0ff456 0000 0 c8
1 0 2a0789 0000 0 c8
2 1 3fffff cafe 0 c8
2 0 155555 0000 0 f0
0 0 3fffff 0000 0 f0
0 1 123456 0f0f 0 620
1 1 234567 f0f0 0 622
2 0 123456 0000 0 624
0 0 234567 0000 0 630
1 0 3fffff 0000 0 640
0 1 000000 9966 3 800
1 1 000000 1122 0 800
2 0 000000 0000 0 810
0 0 0ff456 0000 0 820
1 1 000123 77aa 2 c00
2 0 000123 0000 0 c00

// File: test/tb_sdram_sys.sv
module tb_sdram_sys import sdram_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES   = 64;
    localparam int ACK_TIMEOUT = 200;
    localparam int END_CYCLE   = 4000;

    logic       clk = 1'b0;
    logic       reset;
    logic       refresh;
    logic       req [3];
    logic       we_i [3];
    mem_addr_t  addr_i [3];
    mem_data_t  wdata_i [3];
    byte_mask_t wm_i [3];
    logic       ack [3];
    mem_data_t  rdata [3];

    logic       sdram_cs_n;
    logic       sdram_ras_n;
    logic       sdram_cas_n;
    logic       sdram_we_n;
    row_t       sdram_addr;
    bank_t      sdram_ba;
    wire [15:0] sdram_dq;
    byte_mask_t sdram_dqm;
    int         model_errors;
    logic       init_done;
    int         refresh_count;

    int         c_ch [MAX_CASES];
    logic       c_we [MAX_CASES];
    mem_addr_t  c_addr [MAX_CASES];
    mem_data_t  c_data [MAX_CASES];
    byte_mask_t c_mask [MAX_CASES];
    int         c_start [MAX_CASES];
    int         post_cyc [MAX_CASES];
    int         ack_cyc [MAX_CASES];
    int         ncases = 0;
    int         cycle = 0;
    int         errors = 0;
    int         posts [3];
    int         acks [3];
    mem_data_t  ref_mem [mem_addr_t];

    always #10 clk = ~clk;

    sdram_sys UUT (
        .clk, .reset, .refresh,
        .ch0_req(req[0]), .ch0_we(we_i[0]), .ch0_addr(addr_i[0]), .ch0_wdata(wdata_i[0]),
        .ch0_wm(wm_i[0]), .ch0_ack(ack[0]), .ch0_rdata(rdata[0]),
        .ch1_req(req[1]), .ch1_we(we_i[1]), .ch1_addr(addr_i[1]), .ch1_wdata(wdata_i[1]),
        .ch1_wm(wm_i[1]), .ch1_ack(ack[1]), .ch1_rdata(rdata[1]),
        .ch2_req(req[2]), .ch2_we(we_i[2]), .ch2_addr(addr_i[2]), .ch2_wdata(wdata_i[2]),
        .ch2_wm(wm_i[2]), .ch2_ack(ack[2]), .ch2_rdata(rdata[2]),
        .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n,
        .sdram_addr, .sdram_ba, .sdram_dq, .sdram_dqm
    );

    sdram_model model (
        .clk, .reset, .cs_n(sdram_cs_n), .ras_n(sdram_ras_n), .cas_n(sdram_cas_n),
        .we_n(sdram_we_n), .addr(sdram_addr), .ba(sdram_ba), .dq(sdram_dq),
        .dqm(sdram_dqm), .errors(model_errors), .init_done, .refresh_count
    );

    always @(posedge clk) begin
        if (reset) cycle <= 0;
        else cycle <= cycle + 1;
    end

    // occasional early refresh hint
    initial begin
        void'($urandom(32'h83c3));
        forever begin
            @(posedge clk);
            #1;
            refresh = (($urandom % 32'd64) == 32'd0);
        end
    end

    always @(negedge clk) begin
        for (int n = 0; n < 3; n++) begin
            if (ack[n] === 1'b1) acks[n]++;
        end
    end

    function automatic mem_data_t ref_read(input mem_addr_t a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return a[15:0] ^ {10'd0, a[21:16]};  // the model's power-up pattern
    endfunction

    task automatic ref_write(input mem_addr_t a, input mem_data_t d, input byte_mask_t m);
        mem_data_t old;
        old = ref_read(a);
        ref_mem[a] = {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endtask

    task automatic read_cases();
        int    fd;
        int    f_ch, f_we, f_addr, f_data, f_mask, f_start;
        string line;
        fd = $fopen("test/sdram_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open test/sdram_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && ncases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.substr(0, 0) == "#") continue;
            if ($sscanf(line, "%h %h %h %h %h %h", f_ch, f_we, f_addr, f_data, f_mask,
                        f_start) != 6) continue;
            c_ch[ncases]     = f_ch;
            c_we[ncases]     = (f_we != 0);
            c_addr[ncases]   = mem_addr_t'(f_addr);
            c_data[ncases]   = mem_data_t'(f_data);
            c_mask[ncases]   = byte_mask_t'(f_mask);
            c_start[ncases]  = f_start;
            post_cyc[ncases] = -1;
            ack_cyc[ncases]  = -1;
            ncases++;
        end
        $fclose(fd);
    endtask

    // one channel's requests in file order, each waits for its ack
    task automatic serve_channel(input int n);
        int        guard;
        bit        got;
        mem_data_t expected;
        for (int i = 0; i < ncases; i++) begin
            if (c_ch[i] != n) continue;
            guard = 0;
            do begin
                @(posedge clk);
                #1;
                guard++;
            end while (cycle < c_start[i] && guard < 100000);
            if (cycle < c_start[i]) begin
                $display("channel %0d never reached the start cycle of case %0d", n, i);
                errors++;
            end
            req[n]     = 1'b1;
            we_i[n]    = c_we[i];
            addr_i[n]  = c_addr[i];
            wdata_i[n] = c_data[i];
            wm_i[n]    = c_mask[i];
            post_cyc[i] = cycle;
            posts[n]++;
            @(posedge clk);
            #1;
            req[n] = 1'b0;
            got = 1'b0;
            guard = 0;
            while (!got && guard < ACK_TIMEOUT) begin
                @(negedge clk);
                guard++;
                if (ack[n] === 1'b1) got = 1'b1;
            end
            if (!got) begin
                $display("channel %0d got no ack for case %0d within %0d cycles",
                         n, i, ACK_TIMEOUT);
                errors++;
            end else begin
                ack_cyc[i] = cycle;
                if (c_we[i]) begin
                    ref_write(c_addr[i], c_data[i], c_mask[i]);
                end else begin
                    expected = ref_read(c_addr[i]);
                    if (rdata[n] !== expected) begin
                        $display("Error: ch%0d_rdata = %h, expected %h (addr %h)",
                                 n, rdata[n], expected, c_addr[i]);
                        errors++;
                    end
                end
            end
        end
    endtask

    initial begin
        int guard;
        reset   = 1'b1;
        refresh = 1'b0;
        for (int n = 0; n < 3; n++) begin
            req[n]     = 1'b0;
            we_i[n]    = 1'b0;
            addr_i[n]  = '0;
            wdata_i[n] = '0;
            wm_i[n]    = '0;
            posts[n]   = 0;
            acks[n]    = 0;
        end
        read_cases();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        fork
            serve_channel(0);
            serve_channel(1);
            serve_channel(2);
        join

        guard = 0;
        while (cycle < END_CYCLE && guard < END_CYCLE + 10) begin
            @(posedge clk);
            guard++;
        end
        if (cycle < END_CYCLE) begin
            $display("run stopped short of cycle %0d", END_CYCLE);
            errors++;
        end

        // same-cycle requests must be acked lowest channel first
        for (int i = 0; i < ncases; i++) begin
            for (int j = i + 1; j < ncases; j++) begin
                if (post_cyc[i] >= 0 && post_cyc[i] == post_cyc[j] && c_ch[i] != c_ch[j]
                    && ack_cyc[i] >= 0 && ack_cyc[j] >= 0
                    && ((c_ch[i] < c_ch[j]) != (ack_cyc[i] < ack_cyc[j]))) begin
                    $display("acks for cases %0d and %0d out of priority order", i, j);
                    errors++;
                end
            end
        end
        for (int n = 0; n < 3; n++) begin
            if (acks[n] != posts[n]) begin
                $display("channel %0d saw %0d acks for %0d requests", n, acks[n], posts[n]);
                errors++;
            end
        end
        if (!init_done) begin
            $display("init sequence never completed");
            errors++;
        end
        if (refresh_count < 2) begin
            $display("only %0d periodic refreshes seen", refresh_count);
            errors++;
        end

        $display("errors: testbench %0d, model %0d", errors, model_errors);
        if (errors == 0 && model_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/sdram_model.sv
module sdram_model import sdram_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cs_n,
    input  logic       ras_n,
    input  logic       cas_n,
    input  logic       we_n,
    input  row_t       addr,
    input  bank_t      ba,
    inout  wire [15:0] dq,
    input  byte_mask_t dqm,
    output int         errors,
    output logic       init_done,
    output int         refresh_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int GAP_LIMIT = int'(REFRESH_INTERVAL) + int'(WRITE_PERIOD) + 2;

    sdram_cmd_t cmd;
    mem_data_t  mem [mem_addr_t];
    row_t       open_row [4];
    int         init_step = 0;  // PRE, MRS, AR, AR, done
    int         cycle = 0;
    int         act_cycle = 0;
    int         last_ref = 0;
    logic       act_open = 1'b0;
    logic       rd_wait = 1'b0;
    logic       drive_en = 1'b0;
    mem_data_t  rd_data = '0;
    mem_addr_t  key;
    mem_data_t  old;

    initial errors = 0;
    initial refresh_count = 0;

    // pins mean nothing until the controller leaves reset
    assign cmd       = (reset || cs_n) ? CMD_NOOP : {ras_n, cas_n, we_n};
    assign dq        = drive_en ? rd_data : 'z;
    assign init_done = (init_step == 4);

    // unwritten words read back an address-dependent pattern
    function automatic mem_data_t fill_word(input mem_addr_t a);
        return a[15:0] ^ {10'd0, a[21:16]};
    endfunction

    always @(posedge clk) begin
        cycle = cycle + 1;
        drive_en <= rd_wait;  // CAS latency 2
        rd_wait = 1'b0;
        case (cmd)
            CMD_NOOP: ;
            CMD_PRECHARGE: begin
                if (init_step == 0 && addr[10]) init_step = 1;
                else begin
                    $display("model: precharge out of init order at cycle %0d", cycle);
                    errors++;
                end
            end
            CMD_MODE_REGISTER_SET: begin
                if (init_step != 1) begin
                    $display("model: mode register set out of init order");
                    errors++;
                end
                if (addr != MODE_WORD) begin
                    $display("Error: sdram_addr = %h, expected %h", addr, MODE_WORD);
                    errors++;
                end
                init_step = 2;
            end
            CMD_AUTO_REFRESH: begin
                if (init_step == 2 || init_step == 3) init_step++;
                else if (init_step == 4) begin
                    if (act_open) begin
                        $display("model: refresh inside an open access at cycle %0d", cycle);
                        errors++;
                    end
                    if (refresh_count > 0 && cycle - last_ref > GAP_LIMIT) begin
                        $display("model: refresh gap of %0d cycles too long", cycle - last_ref);
                        errors++;
                    end
                    refresh_count++;
                    last_ref = cycle;
                end else begin
                    $display("model: auto refresh before mode register set");
                    errors++;
                end
            end
            CMD_ACTIVATE: begin
                if (init_step != 4) begin
                    $display("model: activate before init finished");
                    errors++;
                end
                open_row[ba] = addr;
                act_open = 1'b1;
                act_cycle = cycle;
            end
            CMD_READ, CMD_WRITE: begin
                if (!act_open || cycle - act_cycle != 2) begin
                    $display("model: read or write not two cycles after activate");
                    errors++;
                end
                if (!addr[10]) begin
                    $display("model: access without auto precharge");
                    errors++;
                end
                key = {ba, addr[7:0], open_row[ba]};
                old = mem.exists(key) ? mem[key] : fill_word(key);
                if (cmd == CMD_WRITE) begin
                    mem[key] = {dqm[1] ? old[15:8] : dq[15:8], dqm[0] ? old[7:0] : dq[7:0]};
                end else begin
                    rd_data <= old;
                    rd_wait = 1'b1;
                end
                act_open = 1'b0;
            end
            default: begin
                $display("model: unknown command %b at cycle %0d", cmd, cycle);
                errors++;
            end
        endcase
    end

endmodule

// File: rtl/sdram_sys.sv
module sdram_sys import sdram_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       refresh,  // early refresh hint
    input  logic       ch0_req,
    input  logic       ch0_we,
    input  mem_addr_t  ch0_addr,
    input  mem_data_t  ch0_wdata,
    input  byte_mask_t ch0_wm,
    output logic       ch0_ack,
    output mem_data_t  ch0_rdata,
    input  logic       ch1_req,
    input  logic       ch1_we,
    input  mem_addr_t  ch1_addr,
    input  mem_data_t  ch1_wdata,
    input  byte_mask_t ch1_wm,
    output logic       ch1_ack,
    output mem_data_t  ch1_rdata,
    input  logic       ch2_req,
    input  logic       ch2_we,
    input  mem_addr_t  ch2_addr,
    input  mem_data_t  ch2_wdata,
    input  byte_mask_t ch2_wm,
    output logic       ch2_ack,
    output mem_data_t  ch2_rdata,
    output logic       sdram_cs_n,
    output logic       sdram_ras_n,
    output logic       sdram_cas_n,
    output logic       sdram_we_n,
    output row_t       sdram_addr,
    output bank_t      sdram_ba,
    inout  wire [15:0] sdram_dq,
    output byte_mask_t sdram_dqm
);

    logic       refresh_due;
    logic       refresh_start;
    logic       grant_valid;
    ch_id_t     grant_ch;
    mem_addr_t  grant_addr;
    mem_data_t  grant_wdata;
    logic       grant_we;
    byte_mask_t grant_wm;
    logic       grant_take;
    logic       done;
    ch_id_t     done_ch;
    mem_data_t  done_rdata;

    sdram_refresh_timer u_timer (
        .clk, .reset, .refresh, .refresh_start, .refresh_due
    );

    sdram_arbiter u_arbiter (
        .clk, .reset,
        .ch0_req, .ch0_we, .ch0_addr, .ch0_wdata, .ch0_wm, .ch0_ack, .ch0_rdata,
        .ch1_req, .ch1_we, .ch1_addr, .ch1_wdata, .ch1_wm, .ch1_ack, .ch1_rdata,
        .ch2_req, .ch2_we, .ch2_addr, .ch2_wdata, .ch2_wm, .ch2_ack, .ch2_rdata,
        .grant_valid, .grant_ch, .grant_addr, .grant_wdata, .grant_we, .grant_wm,
        .grant_take, .done, .done_ch, .done_rdata
    );

    sdram_ctrl u_ctrl (
        .clk, .reset, .refresh_due, .refresh_start,
        .grant_valid, .grant_ch, .grant_addr, .grant_wdata, .grant_we, .grant_wm,
        .grant_take, .done, .done_ch, .done_rdata,
        .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n,
        .sdram_addr, .sdram_ba, .sdram_dq, .sdram_dqm
    );

endmodule

// File: rtl/sdram_ctrl.sv
module sdram_ctrl import sdram_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       refresh_due,
    output logic       refresh_start,
    input  logic       grant_valid,
    input  ch_id_t     grant_ch,
    input  mem_addr_t  grant_addr,
    input  mem_data_t  grant_wdata,
    input  logic       grant_we,
    input  byte_mask_t grant_wm,
    output logic       grant_take,
    output logic       done,
    output ch_id_t     done_ch,
    output mem_data_t  done_rdata,
    output logic       sdram_cs_n,
    output logic       sdram_ras_n,
    output logic       sdram_cas_n,
    output logic       sdram_we_n,
    output row_t       sdram_addr,
    output bank_t      sdram_ba,
    inout  wire [15:0] sdram_dq,
    output byte_mask_t sdram_dqm
);

    typedef enum logic [1:0] {
        STATE_CONFIGURE,
        STATE_IDLE,
        STATE_ACTIVE,
        STATE_REFRESH
    } ctrl_state_t;

    ctrl_state_t state;
    sdram_cmd_t  cmd;
    logic [4:0]  step;
    col_t        column;
    mem_data_t   data;
    ch_id_t      cur_ch;
    logic        we;
    byte_mask_t  wm;

    assign {sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
    assign sdram_cs_n = (cmd == CMD_NOOP);
    assign sdram_dq   = (cmd == CMD_WRITE) ? data : 'z;

    // refresh wins over a waiting grant
    assign grant_take    = (state == STATE_IDLE) && !refresh_due && grant_valid;
    assign refresh_start = ((state == STATE_IDLE) && refresh_due)
                        || ((state == STATE_CONFIGURE) && (step == CONFIGURE_END));

    assign done       = (state == STATE_ACTIVE) && (step == ACTIVE_READY);
    assign done_ch    = cur_ch;
    assign done_rdata = sdram_dq;  // sampled by the arbiter on done

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= STATE_CONFIGURE;
            cmd       <= CMD_NOOP;
            step      <= '0;
            sdram_dqm <= 2'b11;
        end else begin
            case (state)
                STATE_CONFIGURE: begin
                    step <= step + 5'd1;
                    case (step)
                        CONFIGURE_PRECHARGE: begin
                            sdram_addr[10] <= 1'b1;  // all banks
                            cmd            <= CMD_PRECHARGE;
                        end
                        CONFIGURE_SET_MODE: begin
                            sdram_addr <= MODE_WORD;
                            sdram_ba   <= '0;
                            cmd        <= CMD_MODE_REGISTER_SET;
                        end
                        CONFIGURE_REFRESH_1, CONFIGURE_REFRESH_2: begin
                            cmd <= CMD_AUTO_REFRESH;
                        end
                        CONFIGURE_END: begin
                            cmd   <= CMD_NOOP;
                            state <= STATE_IDLE;
                        end
                        default: cmd <= CMD_NOOP;
                    endcase
                end
                STATE_IDLE: begin
                    cmd       <= CMD_NOOP;
                    step      <= ACTIVE_START;
                    sdram_dqm <= 2'b11;
                    if (refresh_due) begin
                        cmd   <= CMD_AUTO_REFRESH;
                        state <= STATE_REFRESH;
                    end else if (grant_valid) begin
                        {sdram_ba, column, sdram_addr} <= grant_addr;
                        data   <= grant_wdata;
                        we     <= grant_we;
                        wm     <= grant_wm;
                        cur_ch <= grant_ch;
                        cmd    <= CMD_ACTIVATE;
                        state  <= STATE_ACTIVE;
                    end
                end
                STATE_ACTIVE: begin
                    step <= step + 5'd1;
                    case (step)
                        ACTIVE_CMD: begin
                            sdram_addr <= {1'b0, 1'b1, 2'b00, column};  // a10 auto-precharge
                            sdram_dqm  <= we ? wm : 2'b00;
                            cmd        <= we ? CMD_WRITE : CMD_READ;
                        end
                        ACTIVE_READ_END: begin
                            cmd <= CMD_NOOP;
                            if (!we) state <= STATE_IDLE;
                        end
                        ACTIVE_WRITE_END: begin
                            cmd <= CMD_NOOP;
                            if (we) state <= STATE_IDLE;
                        end
                        default: cmd <= CMD_NOOP;
                    endcase
                end
                STATE_REFRESH: begin
                    cmd  <= CMD_NOOP;
                    step <= step + 5'd1;
                    if (step == READ_PERIOD) state <= STATE_IDLE;  // covers tRFC
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

    // the bus is only driven for a write that follows its own activate
    a_dq_write_only: assert property (@(posedge clk) disable iff (reset)
        (cmd == CMD_WRITE) |-> (state == STATE_ACTIVE) && we && ($past(cmd, 2) == CMD_ACTIVATE));

    a_take_in_idle: assert property (@(posedge clk) disable iff (reset)
        grant_take |-> (state == STATE_IDLE) ##1 (cmd == CMD_ACTIVATE));

endmodule

// File: rtl/sdram_arbiter.sv
module sdram_arbiter import sdram_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       ch0_req,
    input  logic       ch0_we,
    input  mem_addr_t  ch0_addr,
    input  mem_data_t  ch0_wdata,
    input  byte_mask_t ch0_wm,
    output logic       ch0_ack,
    output mem_data_t  ch0_rdata,
    input  logic       ch1_req,
    input  logic       ch1_we,
    input  mem_addr_t  ch1_addr,
    input  mem_data_t  ch1_wdata,
    input  byte_mask_t ch1_wm,
    output logic       ch1_ack,
    output mem_data_t  ch1_rdata,
    input  logic       ch2_req,
    input  logic       ch2_we,
    input  mem_addr_t  ch2_addr,
    input  mem_data_t  ch2_wdata,
    input  byte_mask_t ch2_wm,
    output logic       ch2_ack,
    output mem_data_t  ch2_rdata,
    output logic       grant_valid,
    output ch_id_t     grant_ch,
    output mem_addr_t  grant_addr,
    output mem_data_t  grant_wdata,
    output logic       grant_we,
    output byte_mask_t grant_wm,
    input  logic       grant_take,
    input  logic       done,
    input  ch_id_t     done_ch,
    input  mem_data_t  done_rdata
);

    logic [2:0] pending;
    logic [2:0] take_mask;

    assign take_mask   = grant_take ? (3'b001 << grant_ch) : 3'b000;
    assign grant_valid = |pending;

    always_comb begin
        if (pending[0]) grant_ch = 2'd0;  // lowest index wins
        else if (pending[1]) grant_ch = 2'd1;
        else grant_ch = 2'd2;
        case (grant_ch)
            2'd0: {grant_addr, grant_wdata, grant_we, grant_wm} =
                {ch0_addr, ch0_wdata, ch0_we, ch0_wm};
            2'd1: {grant_addr, grant_wdata, grant_we, grant_wm} =
                {ch1_addr, ch1_wdata, ch1_we, ch1_wm};
            default: {grant_addr, grant_wdata, grant_we, grant_wm} =
                {ch2_addr, ch2_wdata, ch2_we, ch2_wm};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending                     <= 3'b000;
            {ch2_ack, ch1_ack, ch0_ack} <= 3'b000;
        end else begin
            pending                     <= (pending | {ch2_req, ch1_req, ch0_req}) & ~take_mask;
            {ch2_ack, ch1_ack, ch0_ack} <= done ? (3'b001 << done_ch) : 3'b000;
        end
    end

    // read data held until the next read on the same channel
    always_ff @(posedge clk) begin
        if (done && done_ch == 2'd0 && !ch0_we) ch0_rdata <= done_rdata;
        if (done && done_ch == 2'd1 && !ch1_we) ch1_rdata <= done_rdata;
        if (done && done_ch == 2'd2 && !ch2_we) ch2_rdata <= done_rdata;
    end

    a_one_ack: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ch2_ack, ch1_ack, ch0_ack}));

endmodule

// File: rtl/sdram_refresh_timer.sv
module sdram_refresh_timer import sdram_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic refresh,        // early refresh hint
    input  logic refresh_start,
    output logic refresh_due
);

    logic [10:0] count;
    logic        early_ok;
    logic        interval_done;

    assign early_ok      = (count >= (REFRESH_INTERVAL >> 1)) && refresh;
    assign interval_done = (count >= REFRESH_INTERVAL);

    always_ff @(posedge clk) begin
        if (reset || refresh_start) begin
            count       <= '0;
            refresh_due <= 1'b0;
        end else begin
            if (!refresh_due) begin
                count <= count + 11'd1;  // hold while waiting for service
            end
            if (interval_done || early_ok) begin
                refresh_due <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/sdram_pkg.sv
package sdram_pkg;

    typedef logic [11:0] row_t;
    typedef logic [7:0]  col_t;
    typedef logic [1:0]  bank_t;
    typedef logic [21:0] mem_addr_t;  // bank, column, row
    typedef logic [15:0] mem_data_t;
    typedef logic [1:0]  byte_mask_t;  // 1 = byte masked
    typedef logic [1:0]  ch_id_t;
    typedef logic [2:0]  sdram_cmd_t;  // ras, cas, we

    localparam sdram_cmd_t CMD_NOOP              = 3'b111;
    localparam sdram_cmd_t CMD_ACTIVATE          = 3'b011;
    localparam sdram_cmd_t CMD_MODE_REGISTER_SET = 3'b000;
    localparam sdram_cmd_t CMD_AUTO_REFRESH      = 3'b001;
    localparam sdram_cmd_t CMD_READ              = 3'b101;
    localparam sdram_cmd_t CMD_WRITE             = 3'b100;
    localparam sdram_cmd_t CMD_PRECHARGE         = 3'b010;

    localparam logic [4:0] PRECHARGE_PERIOD = 5'd2;  // tRP
    localparam logic [4:0] REGISTER_SET     = 5'd2;  // tRSC
    localparam logic [4:0] ACTIVE_TO_CMD    = 5'd2;  // tRCD
    localparam logic [4:0] CAS_LATENCY      = 5'd2;
    localparam logic [4:0] READ_PERIOD      = 5'd6;  // tRAS + tRP
    localparam logic [4:0] WRITE_PERIOD     = 5'd8;  // tRAS + tRP + tWR

    localparam logic [10:0] REFRESH_INTERVAL = 11'd1560;  // 15.625 us per row

    localparam logic [4:0] CONFIGURE_PRECHARGE = PRECHARGE_PERIOD;
    localparam logic [4:0] CONFIGURE_SET_MODE  = CONFIGURE_PRECHARGE + PRECHARGE_PERIOD;
    localparam logic [4:0] CONFIGURE_REFRESH_1 = CONFIGURE_SET_MODE + REGISTER_SET;
    localparam logic [4:0] CONFIGURE_REFRESH_2 = CONFIGURE_REFRESH_1 + READ_PERIOD + 5'd1;
    localparam logic [4:0] CONFIGURE_END       = CONFIGURE_REFRESH_2 + READ_PERIOD;

    localparam logic [4:0] ACTIVE_START     = 5'd1;
    localparam logic [4:0] ACTIVE_CMD       = ACTIVE_TO_CMD;
    localparam logic [4:0] ACTIVE_READY     = ACTIVE_TO_CMD + CAS_LATENCY + 5'd1;
    localparam logic [4:0] ACTIVE_READ_END  = READ_PERIOD;
    localparam logic [4:0] ACTIVE_WRITE_END = WRITE_PERIOD;

    // burst read, single write, sequential, burst length 1
    localparam logic [11:0] MODE_WORD = {2'b00, 1'b1, 2'b00, 3'(CAS_LATENCY), 1'b0, 3'd0};

endpackage
